// File: verilog/mpmc_settings.svh
`ifndef MPMC_SETTINGS_SVH
`define MPMC_SETTINGS_SVH

// ==========================================================================
// Geometry of the line memory and the host data path
// ==========================================================================

// One line is the unit of a Wishbone transfer
`define MPMC_LINE_W 128
// A strip is one beat of the application read return
`define MPMC_STRIP_W 32
`define MPMC_STRIPS 4
// 64 lines of 16 bytes give a 1 KiB byte address space
`define MPMC_LINES 64
`define MPMC_ADR_W 10

// Pending requests between the host port and the controller
`define MPMC_FIFO_DEPTH 4
// Cycles a request may spend outside IDLE before the FSM gives up
`define MPMC_TIMEOUT 64

`endif

// File: verilog/mpmc_pkg.sv
`include "mpmc_settings.svh"

package mpmc_pkg;

	// Controller states
	// The FSM walks them roughly in this order for a read-modify-write
	typedef enum logic [3:0] {
		IDLE,
		PRESET1,
		PRESET2,
		PRESET3,
		WRITE_DATA0,
		WRITE_DATA1,
		WRITE_DATA2,
		WRITE_DATA3,
		READ_DATA0,
		READ_DATA1,
		READ_DATA2,
		ALU,
		WRITE_TRAMP1,
		WAIT_NACK
	} mpmc_state_t;

	// Host command opcodes; everything past STORE is an atomic on one lane
	typedef enum logic [3:0] {
		CMD_LOAD,
		CMD_STORE,
		CMD_ADD,
		CMD_OR,
		CMD_AND,
		CMD_EOR,
		CMD_MIN,
		CMD_MAX,
		CMD_MINU,
		CMD_MAXU
	} mpmc_cmd_t;

	// Host request as it appears on the bus and in the command FIFO
	typedef struct packed {
		logic cyc;
		logic stb;
		mpmc_cmd_t cmd;
		logic [`MPMC_ADR_W-1:0] adr;
		logic [`MPMC_LINE_W/8-1:0] sel;
		logic [`MPMC_LINE_W-1:0] dat;
	} wb_req_t;

	// Host response
	typedef struct packed {
		logic ack;
		logic err;
		logic [`MPMC_LINE_W-1:0] dat;
	} wb_resp_t;

	// One strip beat returned by the line memory
	typedef struct packed {
		logic valid;
		logic [$clog2(`MPMC_STRIPS)-1:0] index;
		logic [`MPMC_STRIP_W-1:0] dat;
	} mpmc_strip_t;

endpackage

// File: verilog/mpmc_wb_port.sv
`include "mpmc_settings.svh"

module mpmc_wb_port import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input wb_req_t wb_req,
	output wb_resp_t wb_resp,
	input logic fifo_full,
	output logic push,
	input logic done,
	input wb_resp_t app_resp
);

	// High while a load or atomic sits in the controller awaiting its data
	logic waiting;

	// A new request is taken only when nothing is awaited and no ack is on the bus.
	// The ack cycle is excluded because the master still holds stb during it
	assign push = wb_req.cyc && wb_req.stb && !waiting && !fifo_full && !wb_resp.ack;

	always_ff @(posedge clk) begin
		// Read data is only meaningful with the completion ack
		if (waiting && done)
			wb_resp.dat <= app_resp.dat;
		if (rst) begin
			waiting <= 1'b0;
			wb_resp.ack <= 1'b0;
			wb_resp.err <= 1'b0;
		end else if (waiting && done) begin
			// Completion of the awaited request becomes a one-cycle ack
			wb_resp.ack <= 1'b1;
			wb_resp.err <= app_resp.err;
			waiting <= 1'b0;
		end else begin
			// Stores are posted, so the ack follows the push directly
			wb_resp.ack <= push && wb_req.cmd == CMD_STORE;
			wb_resp.err <= 1'b0;
			if (push && wb_req.cmd != CMD_STORE)
				waiting <= 1'b1;
		end
	end

endmodule

// File: verilog/mpmc_cmd_fifo.sv
`include "mpmc_settings.svh"

module mpmc_cmd_fifo import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input wb_req_t din,
	output wb_req_t dout,
	output logic empty,
	output logic full
);

	localparam int PTR_W = $clog2(`MPMC_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`MPMC_FIFO_DEPTH + 1);

	wb_req_t buffer [`MPMC_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Writes into a full FIFO and reads from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign empty = count == 0;
	assign full = count == `MPMC_FIFO_DEPTH;

	// The head of the queue is valid whenever empty is low
	assign dout = buffer[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			buffer[wr_ptr] <= din;
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

// File: verilog/mpmc_state_machine.sv
`include "mpmc_settings.svh"

module mpmc_state_machine import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic calib_complete,
	input logic rdy,
	input logic wdf_rdy,
	input logic fifo_empty,
	input wb_req_t fifo_out,
	input logic [$clog2(`MPMC_STRIPS+1)-1:0] req_strip_cnt,
	input logic [$clog2(`MPMC_STRIPS+1)-1:0] resp_strip_cnt,
	input logic rd_data_valid,
	output mpmc_state_t state,
	output logic timed_out
);

	mpmc_state_t next_state;
	logic [$clog2(`MPMC_TIMEOUT):0] to_cnt;

	// ======================================================================
	// Hang detection
	// ======================================================================

	// The counter only runs once calibration is over, so the clear sweep
	// never trips it
	always_ff @(posedge clk) begin
		if (rst || state == IDLE)
			to_cnt <= '0;
		else if (calib_complete)
			to_cnt <= to_cnt + 1'b1;
	end

	assign timed_out = calib_complete && state != IDLE && to_cnt == `MPMC_TIMEOUT - 1;

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb begin
		next_state = state;
		case (state)
		IDLE:
			if (!fifo_empty && calib_complete)
				next_state = PRESET1;
		PRESET1:
			next_state = PRESET2;
		PRESET2:
			next_state = PRESET3;
		// Only a plain store skips the read of the old line
		PRESET3:
			next_state = fifo_out.cmd == CMD_STORE ? WRITE_DATA0 : READ_DATA0;
		// Write command goes out here and waits for the memory to take it
		WRITE_DATA0:
			if (rdy)
				next_state = WRITE_DATA1;
		WRITE_DATA1:
			next_state = WRITE_DATA2;
		WRITE_DATA2:
			next_state = WRITE_DATA3;
		// Data is offered until the memory accepts it
		WRITE_DATA3:
			if (wdf_rdy)
				next_state = IDLE;
		READ_DATA0:
			next_state = READ_DATA1;
		// Stay until every strip command has been accepted
		READ_DATA1:
			if (req_strip_cnt == `MPMC_STRIPS)
				next_state = READ_DATA2;
		// Strips may still be in flight in the memory delay line
		READ_DATA2:
			if (rd_data_valid && resp_strip_cnt == `MPMC_STRIPS)
				next_state = fifo_out.cmd == CMD_LOAD ? WAIT_NACK : ALU;
		ALU:
			next_state = WRITE_TRAMP1;
		WRITE_TRAMP1:
			next_state = WRITE_DATA0;
		WAIT_NACK:
			next_state = IDLE;
		default:
			next_state = IDLE;
		endcase

		// A hung request is abandoned
		if (timed_out)
			next_state = IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

endmodule

// File: verilog/mpmc_app_ctrl.sv
`include "mpmc_settings.svh"

module mpmc_app_ctrl import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input mpmc_state_t state,
	input logic timed_out,
	input wb_req_t fifo_out,
	input logic [`MPMC_LINE_W-1:0] alu_line,
	input logic rdy,
	input logic wdf_rdy,
	input mpmc_strip_t rd_strip,
	output logic app_en,
	output logic app_wr,
	output logic [`MPMC_ADR_W-1:0] app_adr,
	output logic app_wdf_wren,
	output logic [`MPMC_LINE_W-1:0] app_wdf_data,
	output logic [`MPMC_LINE_W/8-1:0] app_wdf_mask,
	output logic [$clog2(`MPMC_STRIPS+1)-1:0] req_strip_cnt,
	output logic [$clog2(`MPMC_STRIPS+1)-1:0] resp_strip_cnt,
	output logic rd_data_valid,
	output logic pop,
	output logic done,
	output wb_resp_t app_resp,
	output logic [`MPMC_LINE_W-1:0] old_line
);

	localparam int STRIP_B = `MPMC_STRIP_W / 8;
	localparam int MASK_W = `MPMC_LINE_W / 8;
	localparam int STRIP_LSB = $clog2(STRIP_B);
	localparam int LINE_LSB = $clog2(MASK_W);
	localparam int IDX_W = $clog2(`MPMC_STRIPS);

	logic is_store;
	logic in_write;
	logic [MASK_W-1:0] lane_en;

	assign is_store = fifo_out.cmd == CMD_STORE;
	assign in_write = state inside {WRITE_DATA0, WRITE_DATA1, WRITE_DATA2, WRITE_DATA3};

	// ======================================================================
	// Application port
	// ======================================================================

	// One read command per strip, then a single line-wide write command
	assign app_en = (state == READ_DATA1 && req_strip_cnt != `MPMC_STRIPS) ||
		state == WRITE_DATA0;
	assign app_wr = state == WRITE_DATA0;
	// The strip field wraps back to zero once all commands are out, so
	// the write address is always line aligned
	assign app_adr = {fifo_out.adr[`MPMC_ADR_W-1:LINE_LSB], req_strip_cnt[IDX_W-1:0],
		{STRIP_LSB{1'b0}}};

	assign app_wdf_wren = state == WRITE_DATA3;
	assign app_wdf_data = is_store ? fifo_out.dat : alu_line;
	// Mask bits are active high, so a set bit keeps the byte in memory.
	// An atomic only touches the four bytes of its lane
	assign lane_en = MASK_W'({STRIP_B{1'b1}}) << (fifo_out.adr[LINE_LSB-1:STRIP_LSB] * STRIP_B);
	assign app_wdf_mask = is_store ? ~fifo_out.sel : ~lane_en;

	// ======================================================================
	// Read strip tracking
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst || state == PRESET1) begin
			req_strip_cnt <= '0;
			resp_strip_cnt <= '0;
			rd_data_valid <= 1'b0;
		end else begin
			if (app_en && rdy && !app_wr)
				req_strip_cnt <= req_strip_cnt + 1'b1;
			if (rd_strip.valid) begin
				resp_strip_cnt <= resp_strip_cnt + 1'b1;
				// Last strip in, the old line is complete
				if (resp_strip_cnt == `MPMC_STRIPS - 1)
					rd_data_valid <= 1'b1;
			end
		end
	end

	// Strips land in their slot whatever order they arrive in
	always_ff @(posedge clk) begin
		if (rd_strip.valid)
			old_line[rd_strip.index*`MPMC_STRIP_W +: `MPMC_STRIP_W] <= rd_strip.dat;
	end

	// ======================================================================
	// Completion
	// ======================================================================

	// Loads finish at WAIT_NACK, atomics just before their write starts.
	// A timeout completes any read that has not answered yet
	assign done = state == WAIT_NACK || state == WRITE_TRAMP1 ||
		(timed_out && !is_store && !in_write);
	assign pop = state == WAIT_NACK || (state == WRITE_DATA3 && wdf_rdy) || timed_out;

	assign app_resp.ack = done;
	assign app_resp.err = timed_out;
	assign app_resp.dat = old_line;

endmodule

// File: verilog/mpmc_rmw_alu.sv
`include "mpmc_settings.svh"

module mpmc_rmw_alu import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input mpmc_cmd_t cmd,
	input logic [$clog2(`MPMC_STRIPS)-1:0] lane,
	input logic [`MPMC_STRIP_W-1:0] operand,
	input logic [`MPMC_LINE_W-1:0] old_line,
	output logic [`MPMC_LINE_W-1:0] alu_line
);

	logic [`MPMC_STRIP_W-1:0] old_lane;
	logic [`MPMC_STRIP_W-1:0] new_lane;
	logic [`MPMC_LINE_W-1:0] merged;
	logic lt_signed;
	logic lt_unsigned;

	always_comb begin
		old_lane = old_line[lane*`MPMC_STRIP_W +: `MPMC_STRIP_W];
		lt_signed = $signed(old_lane) < $signed(operand);
		lt_unsigned = old_lane < operand;

		case (cmd)
		CMD_ADD: new_lane = old_lane + operand;
		CMD_OR: new_lane = old_lane | operand;
		CMD_AND: new_lane = old_lane & operand;
		CMD_EOR: new_lane = old_lane ^ operand;
		CMD_MIN: new_lane = lt_signed ? old_lane : operand;
		CMD_MAX: new_lane = lt_signed ? operand : old_lane;
		CMD_MINU: new_lane = lt_unsigned ? old_lane : operand;
		CMD_MAXU: new_lane = lt_unsigned ? operand : old_lane;
		// Loads and stores leave the lane as it was
		default: new_lane = old_lane;
		endcase

		// Other lanes pass through untouched
		merged = old_line;
		merged[lane*`MPMC_STRIP_W +: `MPMC_STRIP_W] = new_lane;
	end

	// Result is ready in the cycle after ALU, which is WRITE_TRAMP1
	always_ff @(posedge clk) begin
		if (rst)
			alu_line <= '0;
		else
			alu_line <= merged;
	end

endmodule

// File: verilog/mpmc_line_mem.sv
`include "mpmc_settings.svh"

module mpmc_line_mem import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic app_en,
	input logic app_wr,
	input logic [`MPMC_ADR_W-1:0] app_adr,
	input logic app_wdf_wren,
	input logic [`MPMC_LINE_W-1:0] app_wdf_data,
	input logic [`MPMC_LINE_W/8-1:0] app_wdf_mask,
	output logic rdy,
	output logic wdf_rdy,
	output logic calib_complete,
	output mpmc_strip_t rd_strip
);

	localparam int LINE_LSB = $clog2(`MPMC_LINE_W / 8);
	localparam int STRIP_LSB = $clog2(`MPMC_STRIP_W / 8);
	localparam int LAD_W = $clog2(`MPMC_LINES);

	logic [`MPMC_LINE_W-1:0] mem [`MPMC_LINES];
	logic [LAD_W-1:0] clr_adr;
	logic [LAD_W-1:0] wr_line;
	logic [LAD_W-1:0] cmd_line;
	logic [$clog2(`MPMC_STRIPS)-1:0] cmd_idx;
	logic cmd_taken;
	logic wdf_seen;
	logic cmd_fire;
	logic wdf_fire;
	mpmc_strip_t stage1;

	// The back-pressure leaves one idle cycle after every command, and every
	// data offer waits one cycle before it is taken
	assign rdy = calib_complete && !cmd_taken;
	assign wdf_rdy = calib_complete && wdf_seen;
	assign cmd_fire = app_en && rdy;
	assign wdf_fire = app_wdf_wren && wdf_rdy;
	assign cmd_line = app_adr[`MPMC_ADR_W-1:LINE_LSB];
	assign cmd_idx = app_adr[LINE_LSB-1:STRIP_LSB];

	always_ff @(posedge clk) begin
		// Two-stage delay line for read strips
		stage1.index <= cmd_idx;
		stage1.dat <= mem[cmd_line][cmd_idx*`MPMC_STRIP_W +: `MPMC_STRIP_W];
		rd_strip.index <= stage1.index;
		rd_strip.dat <= stage1.dat;
		// A write command parks its line until the data shows up
		if (cmd_fire && app_wr)
			wr_line <= cmd_line;
		if (rst) begin
			clr_adr <= '0;
			calib_complete <= 1'b0;
			cmd_taken <= 1'b0;
			wdf_seen <= 1'b0;
			stage1.valid <= 1'b0;
			rd_strip.valid <= 1'b0;
		end else begin
			if (!calib_complete) begin
				clr_adr <= clr_adr + 1'b1;
				if (clr_adr == `MPMC_LINES - 1)
					calib_complete <= 1'b1;
			end
			cmd_taken <= cmd_fire;
			wdf_seen <= app_wdf_wren && !wdf_seen;
			stage1.valid <= cmd_fire && !app_wr;
			rd_strip.valid <= stage1.valid;
		end
	end

	// Calibration sweeps zeros through the array and byte-masked writes follow
	always_ff @(posedge clk) begin
		if (!calib_complete)
			mem[clr_adr] <= '0;
		else if (wdf_fire)
			for (int b = 0; b < `MPMC_LINE_W / 8; b++)
				if (!app_wdf_mask[b])
					mem[wr_line][b*8 +: 8] <= app_wdf_data[b*8 +: 8];
	end

endmodule

// File: verilog/mpmc_top.sv
`include "mpmc_settings.svh"

module mpmc_top import mpmc_pkg::*; (
	input logic clk,
	input logic rst,
	input wb_req_t wb_req,
	output wb_resp_t wb_resp
);

	// Host side
	logic push;
	logic pop;
	logic fifo_empty;
	logic fifo_full;
	wb_req_t fifo_out;
	logic done;
	wb_resp_t app_resp;

	// Controller internals
	mpmc_state_t state;
	logic timed_out;
	logic [$clog2(`MPMC_STRIPS+1)-1:0] req_strip_cnt;
	logic [$clog2(`MPMC_STRIPS+1)-1:0] resp_strip_cnt;
	logic rd_data_valid;
	logic [`MPMC_LINE_W-1:0] old_line;
	logic [`MPMC_LINE_W-1:0] alu_line;

	// Application port
	logic app_en;
	logic app_wr;
	logic [`MPMC_ADR_W-1:0] app_adr;
	logic app_wdf_wren;
	logic [`MPMC_LINE_W-1:0] app_wdf_data;
	logic [`MPMC_LINE_W/8-1:0] app_wdf_mask;
	logic rdy;
	logic wdf_rdy;
	logic calib_complete;
	mpmc_strip_t rd_strip;

	mpmc_wb_port wb_port_inst (.clk, .rst, .wb_req, .wb_resp, .fifo_full, .push, .done,
		.app_resp);

	mpmc_cmd_fifo cmd_fifo_inst (.clk, .rst, .push, .pop, .din(wb_req), .dout(fifo_out),
		.empty(fifo_empty), .full(fifo_full));

	mpmc_state_machine state_machine_inst (.clk, .rst, .calib_complete, .rdy, .wdf_rdy,
		.fifo_empty, .fifo_out, .req_strip_cnt, .resp_strip_cnt, .rd_data_valid, .state,
		.timed_out);

	mpmc_app_ctrl app_ctrl_inst (.clk, .rst, .state, .timed_out, .fifo_out, .alu_line, .rdy,
		.wdf_rdy, .rd_strip, .app_en, .app_wr, .app_adr, .app_wdf_wren, .app_wdf_data,
		.app_wdf_mask, .req_strip_cnt, .resp_strip_cnt, .rd_data_valid, .pop, .done,
		.app_resp, .old_line);

	// Lane select and operand come straight from the request at the FIFO head
	mpmc_rmw_alu rmw_alu_inst (.clk, .rst, .cmd(fifo_out.cmd),
		.lane(fifo_out.adr[$clog2(`MPMC_LINE_W/8)-1:$clog2(`MPMC_STRIP_W/8)]),
		.operand(fifo_out.dat[`MPMC_STRIP_W-1:0]), .old_line, .alu_line);

	mpmc_line_mem line_mem_inst (.clk, .rst, .app_en, .app_wr, .app_adr, .app_wdf_wren,
		.app_wdf_data, .app_wdf_mask, .rdy, .wdf_rdy, .calib_complete, .rd_strip);

endmodule

// File: test/mpmc_tb.sv
`include "mpmc_settings.svh"

module mpmc_tb import mpmc_pkg::*; ();

	// ======================================================================
	// Run length and stimulus tables
	// ======================================================================

	// Requests issued over all tests, and a generous bound on one request
	localparam int N_REQ = 4 + 16 + 7 + 36 + 12;
	localparam int WORST_REQ = 40;
	localparam int CYCLE_LIMIT = 2 + `MPMC_LINES + N_REQ * WORST_REQ + 20;
	localparam int N_ATOMIC = 12;

	// Atomic cases as opcode, lane value before the update, and operand
	localparam logic [3:0] ATOMIC_CMDS [N_ATOMIC] = '{CMD_ADD, CMD_OR, CMD_AND, CMD_EOR,
		CMD_MIN, CMD_MIN, CMD_MAX, CMD_MAX, CMD_MINU, CMD_MINU, CMD_MAXU, CMD_MAXU};
	localparam logic [31:0] OLD_VALS [N_ATOMIC] = '{32'h7fffffff, 32'h0f0f0000,
		32'hff00ff00, 32'ha5a5a5a5, 32'hfffffffb, 32'h00000003, 32'hfffffffb,
		32'h00000007, 32'hfffffffb, 32'h00000002, 32'hfffffffb, 32'h00000001};
	localparam logic [31:0] OP_VALS [N_ATOMIC] = '{32'h00000001, 32'h00f0f0ff,
		32'h0ff00ff0, 32'hffff0000, 32'h00000003, 32'hfffffffb, 32'h00000003,
		32'hffffffff, 32'h00000003, 32'h80000000, 32'h00000003, 32'h90000000};

	logic clk;
	logic rst;
	wb_req_t wb_req;
	wb_resp_t wb_resp;

	// Shadow of the line memory that starts at zero like the memory after calibration
	logic [`MPMC_LINE_W-1:0] shadow [`MPMC_LINES];
	logic [15:0] lfsr_state = 16'd64;

	// Expected responses hold one entry per request in issue order
	string exp_name_q [$];
	mpmc_cmd_t exp_cmd_q [$];
	logic [`MPMC_LINE_W-1:0] exp_line_q [$];

	string test_name;
	string resp_name;
	mpmc_cmd_t resp_cmd;
	wb_resp_t exp_resp;
	logic ack_prev = 1'b0;
	int cycle_cnt = 0;
	int issued = 0;
	int acked = 0;
	int check_count = 0;
	int error_count = 0;
	int test_checks = 0;
	int test_errors = 0;
	int tests_run = 0;

	mpmc_top mpmc_top_inst (.clk, .rst, .wb_req, .wb_resp);

	always #10 clk = ~clk;

	// ======================================================================
	// Reference model and random source
	// ======================================================================

	// Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic fb;
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [`MPMC_LINE_W-1:0] random_line();
		logic [`MPMC_LINE_W-1:0] r;
		for (int i = 0; i < `MPMC_STRIPS; i++)
			r[i*32 +: 32] = random_bits(32);
		return r;
	endfunction

	// New lane value for each atomic opcode
	function automatic logic [31:0] atomic_result(input mpmc_cmd_t cmd, input logic [31:0] a,
		input logic [31:0] b);
		case (cmd)
		CMD_ADD: return a + b;
		CMD_OR: return a | b;
		CMD_AND: return a & b;
		CMD_EOR: return a ^ b;
		CMD_MIN: return $signed(a) < $signed(b) ? a : b;
		CMD_MAX: return $signed(a) < $signed(b) ? b : a;
		CMD_MINU: return a < b ? a : b;
		CMD_MAXU: return a < b ? b : a;
		default: return a;
		endcase
	endfunction

	// Returns the line as it was before the request and applies the request
	// to the shadow, so a load gets its data and an atomic its old line
	function automatic logic [`MPMC_LINE_W-1:0] model_access(input mpmc_cmd_t cmd,
		input logic [`MPMC_ADR_W-1:0] adr, input logic [15:0] sel,
		input logic [`MPMC_LINE_W-1:0] dat);
		logic [5:0] line;
		logic [1:0] lane;
		logic [`MPMC_LINE_W-1:0] old;
		line = adr[9:4];
		lane = adr[3:2];
		old = shadow[line];
		if (cmd == CMD_STORE) begin
			for (int b = 0; b < 16; b++)
				if (sel[b])
					shadow[line][b*8 +: 8] = dat[b*8 +: 8];
		end else if (cmd != CMD_LOAD) begin
			shadow[line][lane*32 +: 32] = atomic_result(cmd, old[lane*32 +: 32], dat[31:0]);
		end
		return old;
	endfunction

	// ======================================================================
	// Bus driver and compare tasks
	// ======================================================================

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic check_err_flag(input string name, input wb_resp_t exp, input wb_resp_t act);
		check_count++;
		test_checks++;
		if (act.err !== exp.err) begin
			$display("MISMATCH %s: err expected %b actual %b", name, exp.err, act.err);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic check_read_resp(input string name, input wb_resp_t exp, input wb_resp_t act);
		check_count++;
		test_checks++;
		if (act.dat !== exp.dat) begin
			$display("MISMATCH %s: expected %h actual %h", name, exp.dat, act.dat);
			error_count++;
			test_errors++;
		end
	endtask

	// One Wishbone classic cycle that is held until the slave acknowledges it
	task automatic issue_request(input mpmc_cmd_t cmd, input logic [`MPMC_ADR_W-1:0] adr,
		input logic [15:0] sel, input logic [`MPMC_LINE_W-1:0] dat);
		logic [`MPMC_LINE_W-1:0] exp;
		exp = model_access(cmd, adr, sel, dat);
		@(negedge clk);
		exp_name_q.push_back(test_name);
		exp_cmd_q.push_back(cmd);
		exp_line_q.push_back(exp);
		issued++;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.cmd = cmd;
		wb_req.adr = adr;
		wb_req.sel = sel;
		wb_req.dat = dat;
		@(negedge clk);
		while (!wb_resp.ack)
			@(negedge clk);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	// The last ack is compared by the time two more falling edges pass
	task automatic end_test();
		@(negedge clk);
		@(negedge clk);
		if (issued != acked)
			report_error($sformatf("%0d requests issued but %0d acknowledged", issued, acked));
		tests_run++;
		$display("%-18s checks=%0d errors=%0d", test_name, test_checks, test_errors);
	endtask

	// Every ack pops one expected response, and a held ack is a failure
	always @(negedge clk) begin
		if (!rst && wb_resp.ack) begin
			if (ack_prev) begin
				report_error("acknowledge stayed high for more than one cycle");
			end else if (exp_cmd_q.size() == 0) begin
				report_error("acknowledge arrived with no request outstanding");
			end else begin
				resp_name = exp_name_q.pop_front();
				resp_cmd = exp_cmd_q.pop_front();
				exp_resp.ack = 1'b1;
				exp_resp.err = 1'b0;
				exp_resp.dat = exp_line_q.pop_front();
				acked++;
				check_err_flag(resp_name, exp_resp, wb_resp);
				if (resp_cmd != CMD_STORE)
					check_read_resp(resp_name, exp_resp, wb_resp);
			end
		end
		ack_prev = wb_resp.ack;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("ERROR: run went past %0d cycles, the DUT stopped answering", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [`MPMC_ADR_W-1:0] adrs [8];
		logic [`MPMC_ADR_W-1:0] adr;
		logic [`MPMC_LINE_W-1:0] line;
		logic [1:0] lane;
		logic [3:0] c;
		clk = 1'b0;
		rst = 1'b1;
		wb_req = '0;
		for (int i = 0; i < `MPMC_LINES; i++)
			shadow[i] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Loads issued during calibration wait for it and then read zeros
		start_test("load_after_calib");
		for (int i = 0; i < 4; i++)
			issue_request(CMD_LOAD, 10'(random_bits(10)), 16'h0, '0);
		end_test();

		start_test("masked_store_load");
		for (int i = 0; i < 8; i++) begin
			adrs[i] = 10'(random_bits(10));
			issue_request(CMD_STORE, adrs[i], 16'(random_bits(16)), random_line());
		end
		for (int i = 0; i < 8; i++)
			issue_request(CMD_LOAD, adrs[i], 16'h0, '0);
		end_test();

		// Six posted stores to one line overrun the four FIFO entries
		start_test("fifo_fill_order");
		adr = 10'(random_bits(10));
		for (int i = 0; i < 6; i++)
			issue_request(CMD_STORE, adr, 16'(random_bits(16)), random_line());
		issue_request(CMD_LOAD, adr, 16'h0, '0);
		end_test();

		// Seed the lane, apply the atomic, then read the updated line back
		start_test("atomic_ops");
		for (int k = 0; k < N_ATOMIC; k++) begin
			lane = 2'(random_bits(2));
			adr = {6'(random_bits(6)), lane, 2'b00};
			line = random_line();
			line[lane*32 +: 32] = OLD_VALS[k];
			issue_request(CMD_STORE, adr, 16'hffff, line);
			line = random_line();
			line[31:0] = OP_VALS[k];
			issue_request(mpmc_cmd_t'(ATOMIC_CMDS[k]), adr, 16'h0, line);
			issue_request(CMD_LOAD, adr, 16'h0, '0);
		end
		end_test();

		// Random opcodes everywhere must still give no err and one ack per request
		start_test("mixed_traffic");
		for (int i = 0; i < 12; i++) begin
			c = 4'(random_bits(4) % 10);
			issue_request(mpmc_cmd_t'(c), 10'(random_bits(10)), 16'(random_bits(16)),
				random_line());
		end
		end_test();

		$display("tests=%0d checks=%0d errors=%0d", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/mpmc_pkg.sv
verilog/mpmc_wb_port.sv
verilog/mpmc_cmd_fifo.sv
verilog/mpmc_state_machine.sv
verilog/mpmc_app_ctrl.sv
verilog/mpmc_rmw_alu.sv
verilog/mpmc_line_mem.sv
verilog/mpmc_top.sv
test/mpmc_tb.sv

// File: Bender.yml
package:
  name: mpmc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mpmc_pkg.sv
      - verilog/mpmc_wb_port.sv
      - verilog/mpmc_cmd_fifo.sv
      - verilog/mpmc_state_machine.sv
      - verilog/mpmc_app_ctrl.sv
      - verilog/mpmc_rmw_alu.sv
      - verilog/mpmc_line_mem.sv
      - verilog/mpmc_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - test/mpmc_tb.sv
